//--- build.f
+incdir+verif
hw/video_pkg.sv
hw/video_stream_if.sv
hw/csc_rgb2ycbcr.sv
hw/chroma_444to422.sv
hw/video_422_pipe.sv
verif/video_422_pipe_tb.sv

//--- hw/chroma_444to422.sv
`default_nettype none

module chroma_444to422 #(
  parameter int SYNC_WIDTH = 2,
  parameter bit CR_CB_N = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  video_stream_if.snk           in,
  output logic                  de,
  output logic [SYNC_WIDTH-1:0] sync,
  output video_pkg::ycbcr422_t  data
);

  import video_pkg::*;

  // 1-2-1 sum of three components
  typedef logic [COMP_WIDTH+1:0] csum_t;

  logic [2:0]                 de_q;
  logic [2:0][SYNC_WIDTH-1:0] sync_q;

  // 0 newest, 1 centre, 2 oldest
  ycbcr444_t pix_q [3];

  csum_t cr_sum;
  csum_t cb_sum;
  comp_t cr_avg;
  comp_t cb_avg;
  logic  cr_cb_sel;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_q   <= '0;
      sync_q <= '0;
      de     <= 1'b0;
      sync   <= '0;
    end else begin
      de_q   <= {de_q[1:0], in.de};
      sync_q <= {sync_q[1:0], in.sync};
      de     <= de_q[2];
      sync   <= sync_q[2];
    end
  end

  // holding stages only advance on active pixels
  always_ff @(posedge clk) begin
    if (in.de) begin
      pix_q[0] <= in.data;
    end
    if (de_q[0]) begin
      pix_q[1] <= pix_q[0];
    end
    if (de_q[1]) begin
      pix_q[2] <= pix_q[1];
    end
  end

  always_comb begin
    cr_sum = {2'd0, pix_q[0][23:16]} +
             {1'b0, pix_q[1][23:16], 1'b0} +
             {2'd0, pix_q[2][23:16]};
    cb_sum = {2'd0, pix_q[0][7:0]} +
             {1'b0, pix_q[1][7:0], 1'b0} +
             {2'd0, pix_q[2][7:0]};
  end

  // truncating divide by four
  always_ff @(posedge clk) begin
    if (de_q[1]) begin
      cr_avg <= cr_sum[COMP_WIDTH+1:2];
      cb_avg <= cb_sum[COMP_WIDTH+1:2];
    end
  end

  // phase restarts at every blanking gap
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cr_cb_sel <= CR_CB_N;
    end else if (de_q[2]) begin
      cr_cb_sel <= ~cr_cb_sel;
    end else begin
      cr_cb_sel <= CR_CB_N;
    end
  end

  always_ff @(posedge clk) begin
    if (!de_q[2]) begin
      data <= '0;
    end else if (cr_cb_sel) begin
      data <= {cr_avg, pix_q[2][15:8]};
    end else begin
      data <= {cb_avg, pix_q[2][15:8]};
    end
  end

  a_phase_reload: assert property (
    @(posedge clk) disable iff (!rst_n)
    !de_q[2] |=> (cr_cb_sel == CR_CB_N)
  );

  a_blank_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    !de |-> (data == '0)
  );

endmodule

`default_nettype wire

//--- hw/csc_rgb2ycbcr.sv
`default_nettype none

module csc_rgb2ycbcr #(
  parameter int SYNC_WIDTH = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  de,
  input  logic [SYNC_WIDTH-1:0] sync,
  input  video_pkg::rgb_t       rgb,
  video_stream_if.src           out
);

  import video_pkg::*;

  localparam int NUM_PROD = 9;

  // row order y, cb, cr; column order r, g, b
  localparam coef_t COEF [NUM_PROD] = '{
    Y_R,  Y_G,  Y_B,
    CB_R, CB_G, CB_B,
    CR_R, CR_G, CR_B
  };

  logic [1:0]                 de_q;
  logic [1:0][SYNC_WIDTH-1:0] sync_q;

  comp_t     rgb_comp [3];
  acc_t      prod_q [NUM_PROD];
  ycbcr444_t ycc_q;

  // row sum with rounding, scale back and offset
  function automatic comp_t row_to_comp(
    input acc_t p0,
    input acc_t p1,
    input acc_t p2,
    input acc_t offset
  );
    acc_t sum;
    sum = p0 + p1 + p2 + RND;
    sum = sum >>> 8;
    sum = sum + offset;
    return sum[COMP_WIDTH-1:0];
  endfunction

  always_comb begin
    rgb_comp[0] = rgb[23:16];
    rgb_comp[1] = rgb[15:8];
    rgb_comp[2] = rgb[7:0];
  end

  // control pipe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_q   <= '0;
      sync_q <= '0;
    end else begin
      de_q   <= {de_q[0], de};
      sync_q <= {sync_q[0], sync};
    end
  end

  // stage one, nine products
  always_ff @(posedge clk) begin
    if (de) begin
      for (int i = 0; i < NUM_PROD; i++) begin
        prod_q[i] <= COEF[i] * $signed({1'b0, rgb_comp[i % 3]});
      end
    end
  end

  // stage two, row sums packed as cr, y, cb
  always_ff @(posedge clk) begin
    if (de_q[0]) begin
      ycc_q <= {
        row_to_comp(prod_q[6], prod_q[7], prod_q[8], C_OFFSET),
        row_to_comp(prod_q[0], prod_q[1], prod_q[2], Y_OFFSET),
        row_to_comp(prod_q[3], prod_q[4], prod_q[5], C_OFFSET)
      };
    end
  end

  assign out.de   = de_q[1];
  assign out.sync = sync_q[1];
  assign out.data = ycc_q;

  a_de_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(out.de)
  );

  // limited range luma for any rgb input
  a_y_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    out.de |-> (out.data[15:8] inside {[8'd16 : 8'd235]})
  );

endmodule

`default_nettype wire

//--- hw/video_422_pipe.sv
`default_nettype none

module video_422_pipe #(
  parameter int SYNC_WIDTH = 2,
  parameter bit CR_CB_N = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_de,
  input  logic [SYNC_WIDTH-1:0] in_sync,
  input  video_pkg::rgb_t       in_rgb,
  output logic                  out_de,
  output logic [SYNC_WIDTH-1:0] out_sync,
  output video_pkg::ycbcr422_t  out_data
);

  import video_pkg::*;

  // 4:4:4 stream between the two stages
  video_stream_if #(
    .SYNC_WIDTH (SYNC_WIDTH),
    .DATA_WIDTH ($bits(ycbcr444_t))
  ) ycc444_bus ();

  // two cycles
  csc_rgb2ycbcr #(
    .SYNC_WIDTH (SYNC_WIDTH)
  ) csc_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .de    (in_de),
    .sync  (in_sync),
    .rgb   (in_rgb),
    .out   (ycc444_bus.src)
  );

  // four cycles
  chroma_444to422 #(
    .SYNC_WIDTH (SYNC_WIDTH),
    .CR_CB_N    (CR_CB_N)
  ) chroma_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (ycc444_bus.snk),
    .de    (out_de),
    .sync  (out_sync),
    .data  (out_data)
  );

endmodule

`default_nettype wire

//--- hw/video_pkg.sv
`default_nettype none

package video_pkg;

  localparam int COMP_WIDTH = 8;
  localparam int RGB_WIDTH = 3 * COMP_WIDTH;
  localparam int YCBCR444_WIDTH = 3 * COMP_WIDTH;
  localparam int YCBCR422_WIDTH = 2 * COMP_WIDTH;
  localparam int COEF_WIDTH = 9;
  localparam int ACC_WIDTH = 18;

  typedef logic [COMP_WIDTH-1:0] comp_t;

  // r 23:16, g 15:8, b 7:0
  typedef logic [RGB_WIDTH-1:0] rgb_t;

  // cr 23:16, y 15:8, cb 7:0
  typedef logic [YCBCR444_WIDTH-1:0] ycbcr444_t;

  // chroma 15:8, y 7:0
  typedef logic [YCBCR422_WIDTH-1:0] ycbcr422_t;

  typedef logic signed [COEF_WIDTH-1:0] coef_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // bt.601 limited range, scaled by 256
  localparam coef_t Y_R = 9'sd66;
  localparam coef_t Y_G = 9'sd129;
  localparam coef_t Y_B = 9'sd25;
  localparam coef_t CB_R = -9'sd38;
  localparam coef_t CB_G = -9'sd74;
  localparam coef_t CB_B = 9'sd112;
  localparam coef_t CR_R = 9'sd112;
  localparam coef_t CR_G = -9'sd94;
  localparam coef_t CR_B = -9'sd18;

  localparam acc_t Y_OFFSET = 18'sd16;
  localparam acc_t C_OFFSET = 18'sd128;
  localparam acc_t RND = 18'sd128;

endpackage

`default_nettype wire

//--- hw/video_stream_if.sv
`default_nettype none

interface video_stream_if #(
  parameter int SYNC_WIDTH = 2,
  parameter int DATA_WIDTH = 24
);

  // one pixel per clock while de is high, sync valid every cycle
  logic                  de;
  logic [SYNC_WIDTH-1:0] sync;
  logic [DATA_WIDTH-1:0] data;

  modport src (
    output de,
    output sync,
    output data
  );

  modport snk (
    input de,
    input sync,
    input data
  );

endinterface

`default_nettype wire

//--- verif/video_ref.svh
`ifndef VIDEO_REF_SVH
`define VIDEO_REF_SVH

// expected converter output, bt.601 limited range
// rows are rounded, then floored by the shift
function automatic ycbcr444_t rgb_to_ycbcr(input rgb_t rgb);
  int r;
  int g;
  int b;
  int y;
  int cb;
  int cr;
  r = int'(rgb[23:16]);
  g = int'(rgb[15:8]);
  b = int'(rgb[7:0]);
  y = int'(Y_R) * r + int'(Y_G) * g + int'(Y_B) * b + int'(RND);
  cb = int'(CB_R) * r + int'(CB_G) * g + int'(CB_B) * b + int'(RND);
  cr = int'(CR_R) * r + int'(CR_G) * g + int'(CR_B) * b + int'(RND);
  y = (y >>> 8) + int'(Y_OFFSET);
  cb = (cb >>> 8) + int'(C_OFFSET);
  cr = (cr >>> 8) + int'(C_OFFSET);
  return {comp_t'(cr), comp_t'(y), comp_t'(cb)};
endfunction

// field access for the 4:4:4 layout
function automatic comp_t ycc_luma(input ycbcr444_t p);
  return p[15:8];
endfunction

function automatic comp_t ycc_cb(input ycbcr444_t p);
  return p[7:0];
endfunction

function automatic comp_t ycc_cr(input ycbcr444_t p);
  return p[23:16];
endfunction

// 1-2-1 low-pass, truncated
function automatic comp_t chroma_avg(
  input comp_t prev,
  input comp_t centre,
  input comp_t next
);
  int sum;
  sum = int'(prev) + 2 * int'(centre) + int'(next);
  return comp_t'(sum / 4);
endfunction

`endif

//--- verif/video_422_pipe_tb.sv
`default_nettype none

module video_422_pipe_tb;

  import video_pkg::*;

  `include "video_ref.svh"

  localparam int SYNC_WIDTH = 2;
  localparam bit CR_CB_N = 1'b0;
  localparam int RESET_CYCLES = 4;
  localparam int LATENCY = 6;
  localparam int NUM_LINES = 11;
  localparam int DRAIN_CYCLES = 12;

  // line kinds
  localparam int K_RANDOM = 0;
  localparam int K_BLACK = 1;
  localparam int K_WHITE = 2;
  localparam int K_RED = 3;
  localparam int K_GREEN = 4;
  localparam int K_BLUE = 5;
  localparam int K_HOLES = 6;
  localparam int K_EXTREME = 7;

  typedef struct packed {
    logic                  de;
    logic [SYNC_WIDTH-1:0] sync;
    ycbcr422_t             data;
    logic                  chroma_known;
  } expect_t;

  logic                  clk;
  logic                  rst_n;
  logic                  in_de;
  logic [SYNC_WIDTH-1:0] in_sync;
  rgb_t                  in_rgb;
  logic                  out_de;
  logic [SYNC_WIDTH-1:0] out_sync;
  ycbcr422_t             out_data;

  int seed;
  int cycle_count = 0;
  int cycle_limit = 100000;
  int active_sent = 0;
  int active_checked = 0;
  int line_len [NUM_LINES];
  int line_gap [NUM_LINES];
  int line_kind [NUM_LINES];

  expect_t exp_q [$];

  // model state
  ycbcr444_t             model_prev;
  logic                  prev_valid;
  logic                  pend_valid;
  logic                  pend_de;
  logic [SYNC_WIDTH-1:0] pend_sync;
  ycbcr444_t             pend_ycc;
  logic                  phase;

  video_422_pipe #(
    .SYNC_WIDTH (SYNC_WIDTH),
    .CR_CB_N    (CR_CB_N)
  ) video_422_pipe_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_de    (in_de),
    .in_sync  (in_sync),
    .in_rgb   (in_rgb),
    .out_de   (out_de),
    .out_sync (out_sync),
    .out_data (out_data)
  );

  always #2 clk = ~clk;

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_de(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR: out_de got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  task automatic check_sync(input logic [SYNC_WIDTH-1:0] got, input logic [SYNC_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: out_sync got %h expected %h", got, exp);
      abort_run();
    end
  endtask

  // chroma of the very first pixel has no defined predecessor
  task automatic check_data(input ycbcr422_t got, input ycbcr422_t exp, input logic chroma_known);
    if (chroma_known) begin
      if (got !== exp) begin
        $display("ERROR: out_data got %h expected %h", got, exp);
        abort_run();
      end
    end else if (got[7:0] !== exp[7:0]) begin
      $display("ERROR: out_data luma got %h expected %h", got[7:0], exp[7:0]);
      abort_run();
    end
  endtask

  task automatic next_pixel(input int kind, input int idx, output rgb_t px);
    case (kind)
      K_BLACK:   px = 24'h000000;
      K_WHITE:   px = 24'hffffff;
      K_RED:     px = 24'hff0000;
      K_GREEN:   px = 24'h00ff00;
      K_BLUE:    px = 24'h0000ff;
      K_EXTREME: px = idx[0] ? 24'hffffff : 24'h000000;
      default:   px = rgb_t'($random(seed));
    endcase
  endtask

  // garbage rgb in blanking must not leak through
  task automatic drive_cycle(input logic de, input rgb_t px);
    logic [31:0] rnd;
    @(negedge clk);
    rnd = $random(seed);
    in_de = de;
    in_sync = rnd[SYNC_WIDTH-1:0];
    in_rgb = de ? px : rgb_t'($random(seed));
    if (de) begin
      active_sent++;
    end
  endtask

  // one input cycle; the pending sample is finished once its next is known
  task automatic model_step();
    ycbcr444_t cur_ycc;
    ycbcr444_t next_ycc;
    comp_t     cb;
    comp_t     cr;
    expect_t   e;
    cur_ycc = rgb_to_ycbcr(in_rgb);
    if (pend_valid) begin
      e = '0;
      e.de = pend_de;
      e.sync = pend_sync;
      e.chroma_known = 1'b1;
      if (pend_de) begin
        next_ycc = in_de ? cur_ycc : pend_ycc;
        cb = chroma_avg(ycc_cb(model_prev), ycc_cb(pend_ycc), ycc_cb(next_ycc));
        cr = chroma_avg(ycc_cr(model_prev), ycc_cr(pend_ycc), ycc_cr(next_ycc));
        e.data = {(phase ? cr : cb), ycc_luma(pend_ycc)};
        e.chroma_known = prev_valid;
        phase = ~phase;
        model_prev = pend_ycc;
        prev_valid = 1'b1;
      end else begin
        phase = CR_CB_N;
      end
      exp_q.push_back(e);
    end
    pend_valid = 1'b1;
    pend_de = in_de;
    pend_sync = in_sync;
    pend_ycc = cur_ycc;
  endtask

  always @(posedge clk) begin
    expect_t e;
    if (rst_n) begin
      model_step();
      if (exp_q.size() >= LATENCY) begin
        e = exp_q.pop_front();
        check_de(out_de, e.de);
        check_sync(out_sync, e.sync);
        check_data(out_data, e.data, e.chroma_known);
        if (e.de) begin
          active_checked++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  initial begin
    int   total;
    rgb_t px;
    seed = 77;
    clk = 1'b0;
    rst_n = 1'b0;
    in_de = 1'b0;
    in_sync = '0;
    in_rgb = '0;
    model_prev = '0;
    prev_valid = 1'b0;
    pend_valid = 1'b0;
    pend_de = 1'b0;
    pend_sync = '0;
    pend_ycc = '0;
    phase = CR_CB_N;

    // odd and even lengths, single-cycle and longer gaps
    line_len = '{8, 8, 8, 8, 8, 17, 12, 9, 20, 15, 6};
    line_gap = '{3, 1, 4, 2, 5, 1, 7, 2, 1, 3, 1};
    line_kind = '{K_BLACK, K_WHITE, K_RED, K_GREEN, K_BLUE, K_RANDOM,
                  K_HOLES, K_EXTREME, K_RANDOM, K_HOLES, K_RANDOM};

    total = RESET_CYCLES + DRAIN_CYCLES + 1;
    for (int ln = 0; ln < NUM_LINES; ln++) begin
      total += line_len[ln] + line_gap[ln];
      if (line_kind[ln] == K_HOLES) begin
        total += line_len[ln] / 4;
      end
    end
    cycle_limit = total + 50;

    // outputs stay zero until the first sample has crossed the pipe
    // model already lags the input by one sample
    repeat (LATENCY - 1) exp_q.push_back('0);

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int ln = 0; ln < NUM_LINES; ln++) begin
      for (int i = 0; i < line_len[ln]; i++) begin
        if (line_kind[ln] == K_HOLES && i % 4 == 3) begin
          drive_cycle(1'b0, '0);
        end
        next_pixel(line_kind[ln], i, px);
        drive_cycle(1'b1, px);
      end
      repeat (line_gap[ln]) drive_cycle(1'b0, '0);
    end
    repeat (DRAIN_CYCLES) drive_cycle(1'b0, '0);

    if (active_checked == active_sent) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("only %0d of %0d active pixels were checked", active_checked, active_sent);
      abort_run();
    end
  end

endmodule

`default_nettype wire
